/* dv/irq_dispatch_props.sv */
/*
 * Concurrent assertions on the per thread slots
 *  - pending flag holds until acknowledged
 *  - no dispatch to a thread that is already pending
 *  - stored id stays stable while pending
 *  - bind into every thread_irq_slots instance
 */

module irq_dispatch_props
	import irq_types_pkg::*;
	(
	input                          clk,
	input                          reset,
	input  dispatch_t              dispatch,
	input  [NUM_THREADS - 1:0]     irq_ack,
	input  [NUM_THREADS - 1:0]     thread_pending,
	input  irq_id_t                thread_ids[NUM_THREADS]
	);

	// Arbiter only picks idle threads
	no_dispatch_to_pending: assert property (@(posedge clk) disable iff (reset)
		dispatch.valid |-> !thread_pending[dispatch.thread])
		else $error("dispatch targets thread %0d which is already pending", dispatch.thread);

	genvar t;
	generate
		for (t = 0; t < NUM_THREADS; t++)
		begin : slot_chk
			// Only an ack may drop a pending flag
			pending_holds: assert property (@(posedge clk) disable iff (reset)
				thread_pending[t] && !irq_ack[t] |=> thread_pending[t])
				else $error("pending flag of thread %0d dropped without ack", t);

			// Id must not move under a thread that is servicing it
			id_stable: assert property (@(posedge clk) disable iff (reset)
				thread_pending[t] && !irq_ack[t] |=> $stable(thread_ids[t]))
				else $error("stored id of thread %0d changed while pending", t);
		end
	endgenerate

endmodule

bind thread_irq_slots irq_dispatch_props i_irq_dispatch_props(
	.clk            (clk),
	.reset          (reset),
	.dispatch       (dispatch),
	.irq_ack        (irq_ack),
	.thread_pending (thread_pending),
	.thread_ids     (thread_ids));

/* dv/irq_dispatch_tb.sv */
/*
 * Testbench for the interrupt dispatch block
 *  - clock, reset and xorshift stimulus
 *  - APB transfer tasks and a register and latch model
 *  - readback, resume and halt, error responses
 *  - edge delivery, priority, round robin and unmask checks
 */

module irq_dispatch_tb
	import irq_types_pkg::*, apb_regs_pkg::*;
	();

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic [NUM_IRQ_LINES - 1:0] irq_lines;
	logic [NUM_THREADS - 1:0] irq_ack;
	logic [NUM_THREADS - 1:0] thread_en;
	logic [NUM_THREADS - 1:0] irq_pending;
	irq_id_t irq_id[NUM_THREADS];
	logic processor_halt;

	// Model of the registers and of the edge latches
	logic [NUM_THREADS - 1:0] model_en;
	logic [NUM_IRQ_LINES - 1:0] model_mask;
	logic [NUM_IRQ_LINES - 1:0] model_edge;
	logic [NUM_IRQ_LINES - 1:0] model_latched;

	logic [31:0] rng_state;
	int value_errors;
	int timeout_errors;

	irq_dispatch_top i_irq_dispatch_top(
		.clk            (clk),
		.reset          (reset),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.irq_lines      (irq_lines),
		.irq_ack        (irq_ack),
		.thread_en      (thread_en),
		.irq_pending    (irq_pending),
		.irq_id         (irq_id),
		.processor_halt (processor_halt));

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// xorshift32 step on the shared state
	function automatic logic [31:0] rand_word();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Lowest numbered line has priority
	function automatic int lowest_line(input logic [NUM_IRQ_LINES - 1:0] lines);
		int n;
		n = -1;
		for (int i = 0; i < NUM_IRQ_LINES; i++)
		begin
			if (lines[i] && n < 0)
				n = i;
		end
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
		else
		begin
			value_errors++;
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	// Setup cycle then access cycle with the response sampled at the falling edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int cycles;
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= wr;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!apb_rsp.pready && cycles < 16)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!apb_rsp.pready)
		begin
			timeout_errors++;
			$display("Timeout waiting for pready at offset 0x%0h", addr);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// Write lands on this edge
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value("pslverr", err, 1'b0);
	endtask

	task automatic reg_read(input string name, input logic [7:0] addr, input logic [31:0] want);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		check_value("pslverr", err, 1'b0);
		check_value(name, rd, want);
	endtask

	task automatic expect_slverr(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(wr, addr, data, rd, err);
		check_value("pslverr", err, 1'b1);
		check_value("prdata", rd, 32'h0);
	endtask

	task automatic check_regs();
		reg_read("irq_mask", REG_IRQ_MASK, model_mask);
		reg_read("irq_edge", REG_IRQ_EDGE, model_edge);
		reg_read("thread_en", REG_THREAD_EN, model_en);
	endtask

	// Two cycles high is seen by the synchroniser
	task automatic pulse_lines(input logic [NUM_IRQ_LINES - 1:0] pattern);
		@(posedge clk);
		irq_lines <= pattern;
		repeat (2)
			@(posedge clk);
		irq_lines <= '0;
	endtask

	task automatic wait_pending(input logic [NUM_THREADS - 1:0] want, input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (irq_pending !== want && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (irq_pending !== want)
		begin
			timeout_errors++;
			$display("Timeout waiting for irq_pending to reach 0x%0h", want);
		end
		check_value("irq_pending & ~thread_en", irq_pending & ~model_en, 32'h0);
	endtask

	// Ack every pending thread after a random delay and collect the new ids
	task automatic collect_irqs(input logic [NUM_IRQ_LINES - 1:0] want, input int limit);
		logic [NUM_IRQ_LINES - 1:0] seen;
		logic [NUM_THREADS - 1:0] prev;
		logic [NUM_THREADS - 1:0] ack_next;
		int timer[NUM_THREADS];
		int cycles;
		logic done;
		seen = '0;
		cycles = 0;
		done = 1'b0;
		@(negedge clk);
		prev = irq_pending;
		for (int t = 0; t < NUM_THREADS; t++)
			timer[t] = prev[t] ? 1 + int'(rand_word() % 4) : 0;
		while (!done && cycles < limit)
		begin
			@(posedge clk);
			ack_next = '0;
			for (int t = 0; t < NUM_THREADS; t++)
			begin
				if (timer[t] > 0)
				begin
					timer[t]--;
					ack_next[t] = (timer[t] == 0);
				end
			end
			irq_ack <= ack_next;
			@(negedge clk);
			for (int t = 0; t < NUM_THREADS; t++)
			begin
				// A newly pending thread must hold a fresh expected line
				if (irq_pending[t] && !prev[t])
				begin
					assert (want[irq_id[t]] && !seen[irq_id[t]])
					else
					begin
						value_errors++;
						$display("Error: irq_id[%0d] got 0x%0h expected one of 0x%0h not in 0x%0h",
							t, irq_id[t], want, seen);
					end
					seen[irq_id[t]] = 1'b1;
					timer[t] = 1 + int'(rand_word() % 4);
				end
			end
			check_value("irq_pending & ~thread_en", irq_pending & ~model_en, 32'h0);
			prev = irq_pending;
			done = (seen == want) && (irq_pending == '0) && (timer.sum() == 0);
			cycles++;
		end
		@(posedge clk);
		irq_ack <= '0;
		// Every delivered edge line leaves its latch
		model_latched = model_latched & ~want;
		if (!done)
		begin
			timeout_errors++;
			$display("Timeout collecting interrupts, expected 0x%0h but saw 0x%0h", want, seen);
		end
	endtask

	initial
	begin
		logic [31:0] r;
		logic [7:0] pattern;
		logic [7:0] mask;
		int t;
		int first;

		rng_state = 32'h04d5_ac59;
		value_errors = 0;
		timeout_errors = 0;
		reset = 1'b1;
		apb_req = '0;
		irq_lines = '0;
		irq_ack = '0;
		model_en = 4'b0001;
		model_mask = '0;
		model_edge = '0;
		model_latched = '0;
		repeat (16)
			@(posedge clk);
		reset <= 1'b0;

		// Reset values
		@(negedge clk);
		check_value("thread_en", thread_en, model_en);
		check_value("processor_halt", processor_halt, 1'b0);
		check_regs();
		reg_read("thread_pend", REG_THREAD_PEND, 32'h0);

		// Random mask and edge writes with the upper bits dropped
		repeat (8)
		begin
			r = rand_word();
			if (r[31])
			begin
				reg_write(REG_IRQ_MASK, r);
				model_mask = r[7:0];
			end
			else
			begin
				reg_write(REG_IRQ_EDGE, r);
				model_edge = r[7:0];
			end
			check_regs();
		end

		// Resume sets and halt clears
		repeat (12)
		begin
			r = rand_word();
			if (r[30])
			begin
				reg_write(REG_RESUME, r);
				model_en = model_en | r[3:0];
			end
			else
			begin
				reg_write(REG_HALT, r);
				model_en = model_en & ~r[3:0];
			end
			@(negedge clk);
			check_value("thread_en", thread_en, model_en);
			check_value("processor_halt", processor_halt, model_en == '0);
			reg_read("thread_en", REG_THREAD_EN, model_en);
			reg_read("resume", REG_RESUME, model_en);
		end

		// Halting every thread raises the processor halt
		reg_write(REG_HALT, 32'hF);
		model_en = '0;
		@(negedge clk);
		check_value("thread_en", thread_en, model_en);
		check_value("processor_halt", processor_halt, 1'b1);
		reg_read("halt", REG_HALT, model_en);

		// Unmapped offsets 0x1c to 0xff and then read-only writes
		repeat (8)
		begin
			r = rand_word();
			expect_slverr(r[8], 8'h1C + 8'(r[7:0] % 8'hE4), r);
		end
		r = rand_word();
		expect_slverr(1'b1, REG_THREAD_EN, r);
		expect_slverr(1'b1, REG_IRQ_LATCHED, r);
		expect_slverr(1'b1, REG_THREAD_PEND, r);
		check_regs();

		// Edge delivery on all threads with a random mask
		reg_write(REG_RESUME, 32'hF);
		model_en = 4'hF;
		reg_write(REG_IRQ_EDGE, 32'hFF);
		model_edge = 8'hFF;
		r = rand_word();
		mask = r[7:0] | 8'h01;
		pattern = r[15:8] | 8'h03;
		reg_write(REG_IRQ_MASK, mask);
		model_mask = mask;
		pulse_lines(pattern);
		model_latched = pattern;
		collect_irqs(pattern & mask, 400);
		reg_read("irq_latched", REG_IRQ_LATCHED, model_latched);

		// Level mode with idle lines empties the latches
		reg_write(REG_IRQ_EDGE, 32'h0);
		model_latched = '0;
		reg_read("irq_latched", REG_IRQ_LATCHED, model_latched);
		reg_write(REG_IRQ_EDGE, 32'hFF);

		// Thread 3 halted while threads 0 to 2 fill up
		reg_write(REG_HALT, 32'h8);
		model_en = 4'b0111;
		reg_write(REG_IRQ_MASK, 32'hFF);
		pulse_lines(8'h07);
		wait_pending(model_en, 50);
		check_value("irq_id set", (8'h01 << irq_id[0]) | (8'h01 << irq_id[1])
			| (8'h01 << irq_id[2]), 8'h07);

		// Lines 3 and 7 always pulsed and line 7 always masked
		r = rand_word();
		pattern = {r[4:0], 3'b000} | 8'h88;
		mask = {r[12:8], 3'b000} & 8'h7F;
		if ((pattern & mask) == '0)
			mask = mask | 8'h08;
		reg_write(REG_IRQ_MASK, mask);
		model_mask = mask;
		pulse_lines(pattern);
		model_latched = pattern;
		repeat (3)
			@(posedge clk);
		reg_read("irq_latched", REG_IRQ_LATCHED, model_latched);
		@(negedge clk);
		check_value("irq_pending", irq_pending, model_en);

		// The one freed thread takes the lowest unmasked line
		t = int'(rand_word() % 3);
		first = lowest_line(pattern & mask);
		@(posedge clk);
		irq_ack <= 4'(1 << t);
		@(posedge clk);
		irq_ack <= '0;
		wait_pending(model_en, 50);
		check_value($sformatf("irq_id[%0d]", t), irq_id[t], first);
		model_latched[first] = 1'b0;
		collect_irqs(pattern & mask & ~(8'h01 << first), 400);
		reg_read("irq_latched", REG_IRQ_LATCHED, model_latched);

		// Unmasking releases the held lines
		reg_write(REG_IRQ_MASK, 32'hFF);
		model_mask = 8'hFF;
		collect_irqs(pattern & ~mask, 400);
		reg_read("irq_latched", REG_IRQ_LATCHED, model_latched);

		$display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* irq_dispatch_top.f */
verilog/irq_types_pkg.sv
verilog/apb_regs_pkg.sv
verilog/irq_csr.sv
verilog/irq_line_capture.sv
verilog/irq_arbiter.sv
verilog/thread_irq_slots.sv
verilog/irq_dispatch_top.sv
dv/irq_dispatch_props.sv
dv/irq_dispatch_tb.sv

/* verilog/apb_regs_pkg.sv */
/*
 * APB register interface definitions
 *  - address and data widths
 *  - request and response structs
 *  - register offset map
 */

package apb_regs_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	// Master to slave signals
	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [APB_ADDR_W - 1:0] paddr;
		logic [APB_DATA_W - 1:0] pwdata;
	} apb_req_t;

	// Slave to master signals
	typedef struct packed {
		logic [APB_DATA_W - 1:0] prdata;
		logic                    pready;
		logic                    pslverr;
	} apb_rsp_t;

	// Register offsets, decoded without a base address
	typedef enum logic [APB_ADDR_W - 1:0] {
		REG_RESUME      = 8'h00,	// Write 1 sets thread enable
		REG_HALT        = 8'h04,	// Write 1 clears thread enable
		REG_THREAD_EN   = 8'h08,	// Read only
		REG_IRQ_MASK    = 8'h0C,
		REG_IRQ_EDGE    = 8'h10,
		REG_IRQ_LATCHED = 8'h14,	// Read only
		REG_THREAD_PEND = 8'h18 	// Read only
	} csr_offset_e;

endpackage

/* verilog/irq_arbiter.sv */
/*
 * Interrupt arbiter
 *  - fixed priority line select, lowest number first
 *  - level mode lines held back while a thread services them
 *  - round robin choice among enabled idle threads
 */

module irq_arbiter
	import irq_types_pkg::*;
	(
	input                            clk,
	input                            reset,
	input  [NUM_IRQ_LINES - 1:0]     latched,
	input  irq_cfg_t                 irq_cfg,
	input  [NUM_THREADS - 1:0]       thread_en,
	input  [NUM_THREADS - 1:0]       thread_pending,
	input  irq_id_t                  thread_ids[NUM_THREADS],
	output dispatch_t                dispatch
	);

	logic [NUM_IRQ_LINES - 1:0] in_service;
	logic [NUM_IRQ_LINES - 1:0] eligible;
	logic [NUM_THREADS - 1:0] target;
	thread_idx_t last_grant;

	// Lines whose id some thread still holds
	always_comb
	begin
		in_service = '0;
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			if (thread_pending[t])
				in_service[thread_ids[t]] = 1'b1;
		end
	end

	// Edge lines are cleared on dispatch, level lines need the filter
	assign eligible = latched & irq_cfg.mask & ~(~irq_cfg.edge_sel & in_service);

	// Thread is free to take an interrupt
	assign target = thread_en & ~thread_pending;

	always_comb
	begin
		thread_idx_t cand;

		dispatch.valid = (|eligible) && (|target);

		// Downward scan so the lowest line is kept
		dispatch.id = '0;
		for (int i = NUM_IRQ_LINES - 1; i >= 0; i--)
		begin
			if (eligible[i])
				dispatch.id = irq_id_t'(i);
		end

		// Search from the thread after the last grant, with wrap
		// Downward so the nearest candidate is kept
		dispatch.thread = '0;
		for (int k = NUM_THREADS; k >= 1; k--)
		begin
			cand = thread_idx_t'((int'(last_grant) + k) % NUM_THREADS);
			if (target[cand])
				dispatch.thread = cand;
		end
	end

	// Pointer starts at the last thread so thread 0 goes first
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= thread_idx_t'(NUM_THREADS - 1);
		else if (dispatch.valid)
			last_grant <= dispatch.thread;
	end

endmodule

/* verilog/irq_csr.sv */
/*
 * Control registers of the interrupt dispatcher
 *  - zero wait state APB slave
 *  - thread enable with resume (set) and halt (clear)
 *  - line mask and edge select registers
 *  - readback of latched requests and pending flags
 *  - processor halt when no thread runs
 */

module irq_csr
	import irq_types_pkg::*, apb_regs_pkg::*;
	(
	input                              clk,
	input                              reset,

	// APB slave port
	input  apb_req_t                   apb_req,
	output apb_rsp_t                   apb_rsp,

	// Status from the datapath
	input  [NUM_IRQ_LINES - 1:0]       latched,
	input  [NUM_THREADS - 1:0]         thread_pending,

	// Configuration to the datapath
	output irq_cfg_t                   irq_cfg,
	output logic [NUM_THREADS - 1:0]   thread_en,
	output logic                       processor_halt
	);

	csr_offset_e offset;
	logic access;
	logic reg_hit;
	logic reg_ro;
	logic wr_en;
	logic [APB_DATA_W - 1:0] rdata;

	// Offset only, placement is up to the interconnect
	assign offset = csr_offset_e'(apb_req.paddr);

	// Access phase of a transfer
	assign access = apb_req.psel && apb_req.penable;

	// Register decode and read multiplexer
	always_comb
	begin
		reg_hit = 1'b1;
		reg_ro = 1'b0;
		rdata = '0;
		case (offset)
			REG_RESUME, REG_HALT:
				rdata[NUM_THREADS - 1:0] = thread_en;

			REG_THREAD_EN:
			begin
				rdata[NUM_THREADS - 1:0] = thread_en;
				reg_ro = 1'b1;
			end

			REG_IRQ_MASK:
				rdata[NUM_IRQ_LINES - 1:0] = irq_cfg.mask;

			REG_IRQ_EDGE:
				rdata[NUM_IRQ_LINES - 1:0] = irq_cfg.edge_sel;

			REG_IRQ_LATCHED:
			begin
				rdata[NUM_IRQ_LINES - 1:0] = latched;
				reg_ro = 1'b1;
			end

			REG_THREAD_PEND:
			begin
				rdata[NUM_THREADS - 1:0] = thread_pending;
				reg_ro = 1'b1;
			end

			default:
				reg_hit = 1'b0;
		endcase
	end

	// Only legal writes change state
	assign wr_en = access && apb_req.pwrite && reg_hit && !reg_ro;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Thread 0 runs out of reset
			thread_en <= NUM_THREADS'(1);
			irq_cfg <= '0;
		end
		else if (wr_en)
		begin
			case (offset)
				REG_RESUME:
					thread_en <= thread_en | apb_req.pwdata[NUM_THREADS - 1:0];

				REG_HALT:
					thread_en <= thread_en & ~apb_req.pwdata[NUM_THREADS - 1:0];

				REG_IRQ_MASK:
					irq_cfg.mask <= apb_req.pwdata[NUM_IRQ_LINES - 1:0];

				REG_IRQ_EDGE:
					irq_cfg.edge_sel <= apb_req.pwdata[NUM_IRQ_LINES - 1:0];

				default:
					;
			endcase
		end
	end

	// Read data only on reads, zero for unmapped offsets
	assign apb_rsp.prdata = (access && !apb_req.pwrite) ? rdata : '0;
	assign apb_rsp.pready = 1'b1;

	// Unmapped offset, or write to a read-only register
	assign apb_rsp.pslverr = access && (!reg_hit || (apb_req.pwrite && reg_ro));

	// Halt the core once every thread is stopped
	assign processor_halt = thread_en == '0;

endmodule

/* verilog/irq_dispatch_top.sv */
/*
 * Interrupt and thread control block
 *  - APB control registers
 *  - external line capture
 *  - line and thread arbiter
 *  - per thread pending slots
 */

module irq_dispatch_top
	import irq_types_pkg::*, apb_regs_pkg::*;
	(
	input                            clk,
	input                            reset,

	// Register access
	input  apb_req_t                 apb_req,
	output apb_rsp_t                 apb_rsp,

	// External requests
	input  [NUM_IRQ_LINES - 1:0]     irq_lines,

	// Core side
	input  [NUM_THREADS - 1:0]       irq_ack,
	output [NUM_THREADS - 1:0]       thread_en,
	output [NUM_THREADS - 1:0]       irq_pending,
	output irq_id_t                  irq_id[NUM_THREADS],
	output                           processor_halt
	);

	irq_cfg_t irq_cfg;
	dispatch_t dispatch;
	logic [NUM_IRQ_LINES - 1:0] latched;

	irq_csr i_irq_csr(
		.clk            (clk),
		.reset          (reset),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.latched        (latched),
		.thread_pending (irq_pending),
		.irq_cfg        (irq_cfg),
		.thread_en      (thread_en),
		.processor_halt (processor_halt));

	irq_line_capture i_irq_line_capture(
		.clk       (clk),
		.reset     (reset),
		.irq_lines (irq_lines),
		.irq_cfg   (irq_cfg),
		.dispatch  (dispatch),
		.latched   (latched));

	// Slot ids feed back to the level mode filter
	irq_arbiter i_irq_arbiter(
		.clk            (clk),
		.reset          (reset),
		.latched        (latched),
		.irq_cfg        (irq_cfg),
		.thread_en      (thread_en),
		.thread_pending (irq_pending),
		.thread_ids     (irq_id),
		.dispatch       (dispatch));

	thread_irq_slots i_thread_irq_slots(
		.clk            (clk),
		.reset          (reset),
		.dispatch       (dispatch),
		.irq_ack        (irq_ack),
		.thread_pending (irq_pending),
		.thread_ids     (irq_id));

endmodule

/* verilog/irq_line_capture.sv */
/*
 * External interrupt line capture
 *  - two flop synchroniser per line
 *  - rising edge detection on the synchronised level
 *  - edge latch, cleared when its id is dispatched
 *  - level mode follows the synchronised level
 */

module irq_line_capture
	import irq_types_pkg::*;
	(
	input                                clk,
	input                                reset,
	input  [NUM_IRQ_LINES - 1:0]         irq_lines,
	input  irq_cfg_t                     irq_cfg,
	input  dispatch_t                    dispatch,
	output logic [NUM_IRQ_LINES - 1:0]   latched
	);

	logic [NUM_IRQ_LINES - 1:0] sync_meta;
	logic [NUM_IRQ_LINES - 1:0] sync_level;
	logic [NUM_IRQ_LINES - 1:0] level_prev;
	logic [NUM_IRQ_LINES - 1:0] rise;
	logic [NUM_IRQ_LINES - 1:0] taken;
	logic [NUM_IRQ_LINES - 1:0] edge_next;

	// Lines are asynchronous to clk
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sync_meta <= '0;
			sync_level <= '0;
			level_prev <= '0;
		end
		else
		begin
			sync_meta <= irq_lines;
			sync_level <= sync_meta;
			level_prev <= sync_level;
		end
	end

	assign rise = sync_level & ~level_prev;

	// One-hot of the line handed out this cycle
	assign taken = dispatch.valid ? (NUM_IRQ_LINES'(1) << dispatch.id) : '0;

	// A new edge wins over the clear of an older one
	assign edge_next = (latched & ~taken) | rise;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			latched <= '0;
		else
		begin
			// Mode is chosen per line
			latched <= (irq_cfg.edge_sel & edge_next) | (~irq_cfg.edge_sel & sync_level);
		end
	end

endmodule

/* verilog/irq_types_pkg.sv */
/*
 * Interrupt dispatch types
 *  - thread and external line counts
 *  - line number and thread number types
 *  - per-line configuration struct (mask and edge select)
 *  - dispatch request struct from the arbiter to the thread slots
 */

package irq_types_pkg;

	// Hardware threads served by the block
	localparam int NUM_THREADS = 4;

	// External interrupt request lines
	localparam int NUM_IRQ_LINES = 8;

	// Index widths derived from the counts
	localparam int IRQ_ID_W = $clog2(NUM_IRQ_LINES);
	localparam int THREAD_IDX_W = $clog2(NUM_THREADS);

	// Line number, also the interrupt id seen by a thread
	typedef logic [IRQ_ID_W - 1:0] irq_id_t;

	// Thread number
	typedef logic [THREAD_IDX_W - 1:0] thread_idx_t;

	// Software configuration of the lines
	// mask: 1 enables the line
	// edge_sel: 1 selects edge mode, 0 selects level mode
	typedef struct packed {
		logic [NUM_IRQ_LINES - 1:0] mask;
		logic [NUM_IRQ_LINES - 1:0] edge_sel;
	} irq_cfg_t;

	// One interrupt handed to one thread
	// Valid for a single cycle, accepted on the next edge
	typedef struct packed {
		logic        valid;
		thread_idx_t thread;
		irq_id_t     id;
	} dispatch_t;

endpackage

/* verilog/thread_irq_slots.sv */
/*
 * Per thread interrupt slots
 *  - one pending flag per thread, set by dispatch
 *  - interrupt id stored with the flag
 *  - acknowledge from the core clears the flag
 */

module thread_irq_slots
	import irq_types_pkg::*;
	(
	input                              clk,
	input                              reset,
	input  dispatch_t                  dispatch,
	input  [NUM_THREADS - 1:0]         irq_ack,
	output logic [NUM_THREADS - 1:0]   thread_pending,
	output irq_id_t                    thread_ids[NUM_THREADS]
	);

	logic [NUM_THREADS - 1:0] grant;

	// One-hot of the thread receiving an interrupt
	assign grant = dispatch.valid ? (NUM_THREADS'(1) << dispatch.thread) : '0;

	genvar t;
	generate
		for (t = 0; t < NUM_THREADS; t++)
		begin : slot_gen
			// Arbiter never targets a pending thread, so set and ack never collide
			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
					thread_pending[t] <= 1'b0;
				else if (grant[t])
					thread_pending[t] <= 1'b1;
				else if (irq_ack[t])
					thread_pending[t] <= 1'b0;
			end

			// Id only meaningful while pending
			always_ff @(posedge clk)
			begin
				if (grant[t])
					thread_ids[t] <= dispatch.id;
			end
		end
	endgenerate

endmodule
